//--- logic/mult_pkg.sv
//==============================
// Shared types for the multiplier array
// Widths, bus addresses, opcodes, lane states
// and the job and result records
//==============================

`default_nettype none

package mult_pkg;

	// Default operand and product widths
	// The struct fields below are sized with these, so the parameter values
	// set at the top level must match them
	localparam int MULT_DW = 16;
	localparam int MULT_PW = 2 * MULT_DW;

	// Wishbone data bus width
	localparam int WB_DW = 32;

	// Default array shape
	localparam int DEF_NUM_LANES  = 4;
	localparam int DEF_FIFO_DEPTH = 4;

	//==============================
	// Register map
	//==============================
	localparam logic [1:0] CMD_ADR_A    = 2'd0;
	localparam logic [1:0] CMD_ADR_UNS  = 2'd1;
	localparam logic [1:0] CMD_ADR_SGN  = 2'd2;
	localparam logic [1:0] CMD_ADR_STAT = 2'd3;
	localparam logic [1:0] RES_ADR_POP  = 2'd0;
	localparam logic [1:0] RES_ADR_CNT  = 2'd1;

	typedef enum logic {
		OP_UNSIGNED = 1'b0,
		OP_SIGNED   = 1'b1
	} mult_op_e;

	typedef enum logic [1:0] {
		LANE_IDLE  = 2'd0,
		LANE_SWEEP = 2'd1,
		LANE_FIX   = 2'd2,
		LANE_DONE  = 2'd3
	} lane_state_e;

	// One job as handed from the dispatcher to a lane
	typedef struct packed {
		mult_op_e             op;
		logic [MULT_DW-1:0]   multiplicand;
		logic [MULT_DW-1:0]   multiplier;
	} mult_job_t;

	// One finished product as handed from a lane to the collector
	typedef struct packed {
		logic [MULT_PW-1:0]   product;
		mult_op_e             op;
	} mult_result_t;

endpackage

`default_nettype wire

//--- logic/job_dispatch.sv
//==============================
// Job dispatcher
// Command Wishbone slave that stores operand A and
// hands each launch to the lanes in round-robin order
//==============================

`timescale 1ns/1ps
`default_nettype none

module job_dispatch
	import mult_pkg::*;
#(
	parameter int DW        = MULT_DW,
	parameter int NUM_LANES = DEF_NUM_LANES
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmd_cyc,
	input  logic                 cmd_stb,
	input  logic                 cmd_we,
	input  logic [1:0]           cmd_adr,
	input  logic [WB_DW-1:0]     cmd_dat_w,
	input  logic [NUM_LANES-1:0] busy,
	output logic [WB_DW-1:0]     cmd_dat_r,
	output logic                 cmd_ack,
	output mult_job_t            job,
	output logic [NUM_LANES-1:0] start
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [DW-1:0]    operand_a;
	logic [PTR_W-1:0] lane_ptr;
	logic             req;
	logic             is_launch;
	logic             lane_free;
	logic             launch;
	logic             accept;
	mult_op_e         launch_op;
	logic [WB_DW-1:0] rd_data;

	//==============================
	// Request decode
	//==============================

	// A new bus cycle, not counting the cycle in which ack is already out
	assign req       = cmd_cyc & cmd_stb & ~cmd_ack;
	assign is_launch = cmd_we & ((cmd_adr == CMD_ADR_UNS) | (cmd_adr == CMD_ADR_SGN));

	// The lane under the pointer must be idle before a launch can go
	assign lane_free = ~busy[lane_ptr];
	assign launch    = req & is_launch & lane_free;

	// Everything except a launch to a busy lane is acknowledged right away
	assign accept    = req & (~is_launch | lane_free);

	// The address of the B write picks the operation
	assign launch_op = (cmd_adr == CMD_ADR_SGN) ? OP_SIGNED : OP_UNSIGNED;

	// Read mux: status shows the busy bit of every lane
	always_comb
	begin
		rd_data = '0;
		case (cmd_adr)
			CMD_ADR_A:    rd_data = WB_DW'(operand_a);
			CMD_ADR_STAT: rd_data = WB_DW'(busy);
			default:      rd_data = '0;
		endcase
	end

	//==============================
	// Handshake and lane pointer
	//==============================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cmd_ack  <= 1'b0;
			start    <= '0;
			lane_ptr <= '0;
		end
		else
		begin
			// Ack lasts one cycle, since req is masked while ack is high
			cmd_ack <= accept;
			start   <= '0;
			if (launch)
			begin
				// The start pulse lines up with the ack of the launch write
				start[lane_ptr] <= 1'b1;
				if (lane_ptr == PTR_W'(NUM_LANES - 1))
				begin
					lane_ptr <= '0;
				end
				else
				begin
					lane_ptr <= lane_ptr + 1'b1;
				end
			end
		end
	end

	// Operand A, the job record and the read data
	always_ff @(posedge clk)
	begin
		if (accept && cmd_we && (cmd_adr == CMD_ADR_A))
		begin
			operand_a <= cmd_dat_w[DW-1:0];
		end
		if (launch)
		begin
			job.op           <= launch_op;
			job.multiplicand <= operand_a;
			job.multiplier   <= cmd_dat_w[DW-1:0];
		end
		if (accept)
		begin
			cmd_dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

//--- logic/shift_add_lane.sv
//==============================
// Shift-and-add multiplier lane
// Sweeps one multiplier bit per clock, then
// corrects the sign of a signed product
//==============================

`timescale 1ns/1ps
`default_nettype none

module shift_add_lane
	import mult_pkg::*;
#(
	parameter int DW = MULT_DW
)
(
	input  logic         clk,
	input  logic         rst,
	input  mult_job_t    job,
	input  logic         start,
	input  logic         take,
	output logic         busy,
	output logic         done,
	output mult_result_t result
);

	localparam int PW = 2 * DW;
	localparam int CW = $clog2(DW) + 1;

	lane_state_e   state;
	logic [CW-1:0] cnt;
	logic [PW-1:0] mcand;
	logic [PW-1:0] acc;
	logic [DW-1:0] mplier;
	logic [DW-1:0] a_mag;
	logic [DW-1:0] b_mag;
	logic          job_neg;
	logic          neg;
	mult_op_e      op_q;

	//==============================
	// Operand magnitudes
	//==============================

	// For signed jobs the sweep works on absolute values
	// The most negative value maps onto its own bit pattern, which is the right magnitude
	always_comb
	begin
		a_mag = job.multiplicand;
		b_mag = job.multiplier;
		if (job.op == OP_SIGNED)
		begin
			if (job.multiplicand[DW-1])
			begin
				a_mag = ~job.multiplicand + 1'b1;
			end
			if (job.multiplier[DW-1])
			begin
				b_mag = ~job.multiplier + 1'b1;
			end
		end
	end

	// Product is negative when exactly one signed operand is negative
	assign job_neg = (job.op == OP_SIGNED) & (job.multiplicand[DW-1] ^ job.multiplier[DW-1]);

	//==============================
	// Lane FSM
	//==============================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= LANE_IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				LANE_IDLE:
				begin
					if (start)
					begin
						state <= LANE_SWEEP;
						cnt   <= '0;
					end
				end
				LANE_SWEEP:
				begin
					// DW sweep cycles, one per multiplier bit
					cnt <= cnt + 1'b1;
					if (cnt == CW'(DW - 1))
					begin
						state <= LANE_FIX;
					end
				end
				LANE_FIX:
				begin
					state <= LANE_DONE;
				end
				default:
				begin
					// Result is held until the collector takes it
					if (take)
					begin
						state <= LANE_IDLE;
					end
				end
			endcase
		end
	end

	// Datapath follows the FSM state
	always_ff @(posedge clk)
	begin
		case (state)
			LANE_IDLE:
			begin
				if (start)
				begin
					mcand  <= PW'(a_mag);
					mplier <= b_mag;
					acc    <= '0;
					neg    <= job_neg;
					op_q   <= job.op;
				end
			end
			LANE_SWEEP:
			begin
				// Add the shifted multiplicand for a set bit
				if (mplier[0])
				begin
					acc <= acc + mcand;
				end
				mcand  <= mcand << 1;
				mplier <= mplier >> 1;
			end
			LANE_FIX:
			begin
				if (neg)
				begin
					acc <= ~acc + 1'b1;
				end
			end
			default:
			begin
			end
		endcase
	end

	assign busy           = (state != LANE_IDLE);
	assign done           = (state == LANE_DONE);
	assign result.product = acc;
	assign result.op      = op_q;

endmodule

`default_nettype wire

//--- logic/result_collect.sv
//==============================
// Result collector
// Drains the lanes in round-robin order into a FIFO
// that the result Wishbone slave pops
//==============================

`timescale 1ns/1ps
`default_nettype none

module result_collect
	import mult_pkg::*;
#(
	parameter int NUM_LANES  = DEF_NUM_LANES,
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [NUM_LANES-1:0] done,
	input  mult_result_t         lane_result [NUM_LANES],
	input  logic                 res_cyc,
	input  logic                 res_stb,
	input  logic                 res_we,
	input  logic [1:0]           res_adr,
	input  logic [WB_DW-1:0]     res_dat_w,
	output logic [NUM_LANES-1:0] take,
	output logic [WB_DW-1:0]     res_dat_r,
	output logic                 res_ack
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int AW    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	mult_result_t     fifo_mem [FIFO_DEPTH];
	logic [AW-1:0]    wr_idx;
	logic [AW-1:0]    rd_idx;
	logic [CNT_W-1:0] fifo_count;
	logic [PTR_W-1:0] lane_ptr;
	logic             fifo_full;
	logic             fifo_empty;
	logic             push;
	logic             pop;
	logic             req;
	logic [WB_DW-1:0] rd_data;

	assign fifo_full  = (fifo_count == CNT_W'(FIFO_DEPTH));
	assign fifo_empty = (fifo_count == '0);

	//==============================
	// Lane drain
	//==============================

	// Only the lane under the pointer is looked at, so order matches launch order
	assign push = done[lane_ptr] & ~fifo_full;

	always_comb
	begin
		take           = '0;
		take[lane_ptr] = push;
	end

	// Result port requests, masked while ack is out
	assign req = res_cyc & res_stb & ~res_ack;
	assign pop = req & ~res_we & (res_adr == RES_ADR_POP) & ~fifo_empty;

	// An empty pop reads as zero
	always_comb
	begin
		rd_data = '0;
		case (res_adr)
			RES_ADR_POP: rd_data = fifo_empty ? '0 : WB_DW'(fifo_mem[rd_idx].product);
			RES_ADR_CNT: rd_data = WB_DW'(fifo_count);
			default:     rd_data = '0;
		endcase
	end

	//==============================
	// Pointers and FIFO count
	//==============================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			lane_ptr   <= '0;
			wr_idx     <= '0;
			rd_idx     <= '0;
			fifo_count <= '0;
			res_ack    <= 1'b0;
		end
		else
		begin
			res_ack <= req;
			if (push)
			begin
				lane_ptr <= (lane_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
				wr_idx   <= (wr_idx == AW'(FIFO_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
			end
			if (pop)
			begin
				rd_idx <= (rd_idx == AW'(FIFO_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
			end
			// Both a push and a pop in one cycle leave the count unchanged
			case ({push, pop})
				2'b10:   fifo_count <= fifo_count + 1'b1;
				2'b01:   fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
		end
	end

	// FIFO storage and read data
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			fifo_mem[wr_idx] <= lane_result[lane_ptr];
		end
		if (req)
		begin
			// Writes are acknowledged and their data dropped
			res_dat_r <= res_we ? '0 : rd_data;
		end
	end

endmodule

`default_nettype wire

//--- logic/seq_mult_array.sv
//==============================
// Multiplier array top level
// Dispatcher, a row of identical lanes and
// the result collector
//==============================

`timescale 1ns/1ps
`default_nettype none

module seq_mult_array
	import mult_pkg::*;
#(
	parameter int DW         = MULT_DW,
	parameter int NUM_LANES  = DEF_NUM_LANES,
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
	input  logic             clk,
	input  logic             rst,
	// Command port
	input  logic             cmd_cyc,
	input  logic             cmd_stb,
	input  logic             cmd_we,
	input  logic [1:0]       cmd_adr,
	input  logic [WB_DW-1:0] cmd_dat_w,
	output logic [WB_DW-1:0] cmd_dat_r,
	output logic             cmd_ack,
	// Result port
	input  logic             res_cyc,
	input  logic             res_stb,
	input  logic             res_we,
	input  logic [1:0]       res_adr,
	input  logic [WB_DW-1:0] res_dat_w,
	output logic [WB_DW-1:0] res_dat_r,
	output logic             res_ack
);

	mult_job_t            job;
	logic [NUM_LANES-1:0] start;
	logic [NUM_LANES-1:0] busy;
	logic [NUM_LANES-1:0] done;
	logic [NUM_LANES-1:0] take;
	mult_result_t         lane_result [NUM_LANES];

	job_dispatch #(
		.DW        (DW),
		.NUM_LANES (NUM_LANES)
	) job_dispatch_inst (
		.clk       (clk),
		.rst       (rst),
		.cmd_cyc   (cmd_cyc),
		.cmd_stb   (cmd_stb),
		.cmd_we    (cmd_we),
		.cmd_adr   (cmd_adr),
		.cmd_dat_w (cmd_dat_w),
		.busy      (busy),
		.cmd_dat_r (cmd_dat_r),
		.cmd_ack   (cmd_ack),
		.job       (job),
		.start     (start)
	);

	// All lanes share the job bus and differ only in their start strobe
	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		shift_add_lane #(
			.DW (DW)
		) shift_add_lane_inst (
			.clk    (clk),
			.rst    (rst),
			.job    (job),
			.start  (start[i]),
			.take   (take[i]),
			.busy   (busy[i]),
			.done   (done[i]),
			.result (lane_result[i])
		);
	end

	result_collect #(
		.NUM_LANES  (NUM_LANES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) result_collect_inst (
		.clk         (clk),
		.rst         (rst),
		.done        (done),
		.lane_result (lane_result),
		.res_cyc     (res_cyc),
		.res_stb     (res_stb),
		.res_we      (res_we),
		.res_adr     (res_adr),
		.res_dat_w   (res_dat_w),
		.take        (take),
		.res_dat_r   (res_dat_r),
		.res_ack     (res_ack)
	);

endmodule

`default_nettype wire

//--- verif/seq_mult_array_checker.sv
//==============================
// Protocol checker for the multiplier array
// Wishbone handshakes, lane strobes and FIFO level
//==============================

`timescale 1ns/1ps
`default_nettype none

module seq_mult_array_checker
#(
	parameter int NUM_LANES  = 4,
	parameter int FIFO_DEPTH = 4
)
(
	input logic                               clk,
	input logic                               rst,
	input logic                               cmd_cyc,
	input logic                               cmd_stb,
	input logic                               cmd_ack,
	input logic                               res_cyc,
	input logic                               res_stb,
	input logic                               res_ack,
	input logic [NUM_LANES-1:0]               start,
	input logic [NUM_LANES-1:0]               busy,
	input logic [NUM_LANES-1:0]               take,
	input logic [NUM_LANES-1:0]               done,
	input logic [$clog2(FIFO_DEPTH+1)-1:0]    fifo_count
);

	//==============================
	// Wishbone handshakes
	//==============================

	// Each ack is a single-cycle pulse
	cmd_ack_pulse: assert property (@(posedge clk) disable iff (!rst) cmd_ack |=> !cmd_ack)
		else $error("cmd_ack stayed high for more than one cycle");
	res_ack_pulse: assert property (@(posedge clk) disable iff (!rst) res_ack |=> !res_ack)
		else $error("res_ack stayed high for more than one cycle");

	// The master holds its request until ack, so ack never shows up without one
	cmd_ack_req: assert property (@(posedge clk) disable iff (!rst) cmd_ack |-> cmd_cyc && cmd_stb)
		else $error("cmd_ack without cmd_cyc and cmd_stb");
	res_ack_req: assert property (@(posedge clk) disable iff (!rst) res_ack |-> res_cyc && res_stb)
		else $error("res_ack without res_cyc and res_stb");

	//==============================
	// Lane strobes and FIFO
	//==============================
	start_to_idle: assert property (@(posedge clk) disable iff (!rst) (start & busy) == '0)
		else $error("start pulsed to a busy lane");

	// A take empties the lane that held the result, so its done is gone one cycle later
	take_clears_done: assert property (@(posedge clk) disable iff (!rst)
		take != '0 |=> (done & $past(take)) == '0)
		else $error("lane kept done high after its result was taken");

	fifo_bound: assert property (@(posedge clk) disable iff (!rst) fifo_count <= FIFO_DEPTH)
		else $error("result FIFO count above its depth");

endmodule

// The FIFO count lives inside the collector instance
bind seq_mult_array seq_mult_array_checker #(
	.NUM_LANES  (NUM_LANES),
	.FIFO_DEPTH (FIFO_DEPTH)
) seq_mult_array_checker_inst (
	.clk        (clk),
	.rst        (rst),
	.cmd_cyc    (cmd_cyc),
	.cmd_stb    (cmd_stb),
	.cmd_ack    (cmd_ack),
	.res_cyc    (res_cyc),
	.res_stb    (res_stb),
	.res_ack    (res_ack),
	.start      (start),
	.busy       (busy),
	.take       (take),
	.done       (done),
	.fifo_count (result_collect_inst.fifo_count)
);

`default_nettype wire

//--- verif/seq_mult_array_tb.sv
//==============================
// Testbench for the multiplier array
// Edge and random jobs go in through the command port,
// results are checked in launch order at the result port
//==============================

`timescale 1ns/1ps
`default_nettype none

module seq_mult_array_tb
	import mult_pkg::*;
();

	localparam int DW         = MULT_DW;
	localparam int PW         = MULT_PW;
	localparam int NUM_LANES  = DEF_NUM_LANES;
	localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
	localparam int CLK_PERIOD = 40;
	localparam int N_RAND     = 8;
	localparam int N_FULL     = FIFO_DEPTH + NUM_LANES;
	// Unsigned, signed, lane fill and back-pressure jobs
	localparam int NUM_JOBS   = (4 + N_RAND) + (6 + N_RAND) + NUM_LANES + (N_FULL + 2);
	localparam longint TIMEOUT_NS = longint'(NUM_JOBS) * (DW + 10) * 4 * CLK_PERIOD + 10000;

	logic             clk;
	logic             rst;
	logic             cmd_cyc;
	logic             cmd_stb;
	logic             cmd_we;
	logic [1:0]       cmd_adr;
	logic [WB_DW-1:0] cmd_dat_w;
	logic [WB_DW-1:0] cmd_dat_r;
	logic             cmd_ack;
	logic             res_cyc;
	logic             res_stb;
	logic             res_we;
	logic [1:0]       res_adr;
	logic [WB_DW-1:0] res_dat_w;
	logic [WB_DW-1:0] res_dat_r;
	logic             res_ack;

	logic [31:0]      lfsr_state;
	logic [DW-1:0]    cur_a;
	logic [PW-1:0]    exp_q [$];
	string            name_q [$];
	int               pass_count;
	int               fail_count;
	logic             stalled_done;

	seq_mult_array #(
		.DW         (DW),
		.NUM_LANES  (NUM_LANES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) seq_mult_array_inst (
		.clk       (clk),
		.rst       (rst),
		.cmd_cyc   (cmd_cyc),
		.cmd_stb   (cmd_stb),
		.cmd_we    (cmd_we),
		.cmd_adr   (cmd_adr),
		.cmd_dat_w (cmd_dat_w),
		.cmd_dat_r (cmd_dat_r),
		.cmd_ack   (cmd_ack),
		.res_cyc   (res_cyc),
		.res_stb   (res_stb),
		.res_we    (res_we),
		.res_adr   (res_adr),
		.res_dat_w (res_dat_w),
		.res_dat_r (res_dat_r),
		.res_ack   (res_ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//==============================
	// Stimulus and expected values
	//==============================

	// Galois LFSR, one step per random bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	task automatic rand_operand(output logic [DW-1:0] val);
		for (int i = 0; i < DW; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[DW-2:0], lfsr_state[0]};
		end
	endtask

	// Expected product straight from the arithmetic definition
	function automatic logic [PW-1:0] ref_mult(input mult_op_e op, input logic [DW-1:0] a,
		input logic [DW-1:0] b);
		logic signed [PW-1:0] sa;
		logic signed [PW-1:0] sb;
		sa = {{DW{a[DW-1]}}, a};
		sb = {{DW{b[DW-1]}}, b};
		if (op == OP_SIGNED)
		begin
			return sa * sb;
		end
		return {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
	endfunction

	//==============================
	// Wishbone bus cycles
	//==============================

	// The request is held until ack is seen at a rising edge
	task automatic cmd_cycle(input logic we, input logic [1:0] adr, input logic [WB_DW-1:0] wdata,
		output logic [WB_DW-1:0] rdata);
		@(posedge clk);
		cmd_cyc   <= 1'b1;
		cmd_stb   <= 1'b1;
		cmd_we    <= we;
		cmd_adr   <= adr;
		cmd_dat_w <= wdata;
		do
		begin
			@(posedge clk);
		end
		while (!cmd_ack);
		rdata = cmd_dat_r;
		cmd_cyc <= 1'b0;
		cmd_stb <= 1'b0;
		cmd_we  <= 1'b0;
	endtask

	task automatic res_cycle(input logic we, input logic [1:0] adr, input logic [WB_DW-1:0] wdata,
		output logic [WB_DW-1:0] rdata);
		@(posedge clk);
		res_cyc   <= 1'b1;
		res_stb   <= 1'b1;
		res_we    <= we;
		res_adr   <= adr;
		res_dat_w <= wdata;
		do
		begin
			@(posedge clk);
		end
		while (!res_ack);
		rdata = res_dat_r;
		res_cyc <= 1'b0;
		res_stb <= 1'b0;
		res_we  <= 1'b0;
	endtask

	task automatic set_operand_a(input logic [DW-1:0] a);
		logic [WB_DW-1:0] rdata;
		cmd_cycle(1'b1, CMD_ADR_A, WB_DW'(a), rdata);
		cur_a = a;
	endtask

	// Expected value is queued before the B write, so it is there before the result
	task automatic launch(input mult_op_e op, input logic [DW-1:0] b);
		logic [WB_DW-1:0] rdata;
		exp_q.push_back(ref_mult(op, cur_a, b));
		name_q.push_back($sformatf("%s %h*%h", op.name(), cur_a, b));
		cmd_cycle(1'b1, (op == OP_SIGNED) ? CMD_ADR_SGN : CMD_ADR_UNS, WB_DW'(b), rdata);
	endtask

	task automatic run_job(input mult_op_e op, input logic [DW-1:0] a, input logic [DW-1:0] b);
		set_operand_a(a);
		launch(op, b);
	endtask

	//==============================
	// Checks
	//==============================
	task automatic check_product(input string name, input logic [PW-1:0] exp,
		input logic [PW-1:0] act);
		if (act === exp)
		begin
			pass_count++;
			$display("Pass %s: %h", name, act);
		end
		else
		begin
			fail_count++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input logic [WB_DW-1:0] exp,
		input logic [WB_DW-1:0] act);
		if (act === exp)
		begin
			pass_count++;
			$display("Pass %s: %h", name, act);
		end
		else
		begin
			fail_count++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Pops n results in order, reading the count first so a pop never finds the FIFO empty
	task automatic drain_and_compare(input int n);
		logic [WB_DW-1:0] rdata;
		for (int i = 0; i < n; i++)
		begin
			rdata = '0;
			while (rdata == '0)
			begin
				res_cycle(1'b0, RES_ADR_CNT, '0, rdata);
			end
			res_cycle(1'b0, RES_ADR_POP, '0, rdata);
			check_product(name_q.pop_front(), exp_q.pop_front(), rdata[PW-1:0]);
		end
	endtask

	//==============================
	// Test sequence
	//==============================
	initial
	begin : main_seq
		logic [DW-1:0]    op_a;
		logic [DW-1:0]    op_b;
		logic [WB_DW-1:0] rdata;
		clk          = 1'b0;
		rst          = 1'b0;
		cmd_cyc      = 1'b0;
		cmd_stb      = 1'b0;
		cmd_we       = 1'b0;
		cmd_adr      = '0;
		cmd_dat_w    = '0;
		res_cyc      = 1'b0;
		res_stb      = 1'b0;
		res_we       = 1'b0;
		res_adr      = '0;
		res_dat_w    = '0;
		lfsr_state   = 32'h7c07758c;
		cur_a        = '0;
		pass_count   = 0;
		fail_count   = 0;
		stalled_done = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;

		// Idle state right after reset
		cmd_cycle(1'b0, CMD_ADR_STAT, '0, rdata);
		check_status("busy after reset", '0, rdata);
		res_cycle(1'b0, RES_ADR_CNT, '0, rdata);
		check_status("count after reset", '0, rdata);

		// A pop from the empty FIFO reads zero and leaves the count alone
		res_cycle(1'b0, RES_ADR_POP, '0, rdata);
		check_product("empty pop", '0, rdata[PW-1:0]);
		res_cycle(1'b0, RES_ADR_CNT, '0, rdata);
		check_status("count after empty pop", '0, rdata);

		// Unsigned edge values, then random operands
		fork
			begin
				run_job(OP_UNSIGNED, 16'h0000, 16'h1234);
				run_job(OP_UNSIGNED, 16'h0001, 16'hbeef);
				run_job(OP_UNSIGNED, 16'hffff, 16'hffff);
				run_job(OP_UNSIGNED, 16'hffff, 16'h0001);
				for (int i = 0; i < N_RAND; i++)
				begin
					rand_operand(op_a);
					rand_operand(op_b);
					run_job(OP_UNSIGNED, op_a, op_b);
				end
			end
			drain_and_compare(4 + N_RAND);
		join

		// Signed edge values around the most negative and largest positive numbers
		fork
			begin
				run_job(OP_SIGNED, 16'h8000, 16'h8000);
				run_job(OP_SIGNED, 16'h8000, 16'hffff);
				run_job(OP_SIGNED, 16'hffff, 16'hffff);
				run_job(OP_SIGNED, 16'h7fff, 16'h7fff);
				run_job(OP_SIGNED, 16'h8000, 16'h7fff);
				run_job(OP_SIGNED, 16'h7fff, 16'hffff);
				for (int i = 0; i < N_RAND; i++)
				begin
					rand_operand(op_a);
					rand_operand(op_b);
					run_job(OP_SIGNED, op_a, op_b);
				end
			end
			drain_and_compare(6 + N_RAND);
		join

		// One operand A and back to back launches keep every lane busy at once
		fork
			begin
				rand_operand(op_a);
				set_operand_a(op_a);
				for (int i = 0; i < NUM_LANES; i++)
				begin
					rand_operand(op_b);
					launch((i % 2 == 1) ? OP_SIGNED : OP_UNSIGNED, op_b);
				end
				cmd_cycle(1'b0, CMD_ADR_STAT, '0, rdata);
				check_status("all lanes busy", WB_DW'({NUM_LANES{1'b1}}), rdata);
			end
			drain_and_compare(NUM_LANES);
		join

		// Back-pressure with the result port left alone
		for (int i = 0; i < N_FULL; i++)
		begin
			rand_operand(op_a);
			rand_operand(op_b);
			run_job((i % 2 == 1) ? OP_SIGNED : OP_UNSIGNED, op_a, op_b);
		end
		cmd_cycle(1'b0, CMD_ADR_STAT, '0, rdata);
		check_status("lanes busy at full FIFO", WB_DW'({NUM_LANES{1'b1}}), rdata);
		res_cycle(1'b0, RES_ADR_CNT, '0, rdata);
		check_status("count at full FIFO", WB_DW'(FIFO_DEPTH), rdata);
		fork
			begin
				for (int i = 0; i < 2; i++)
				begin
					rand_operand(op_a);
					rand_operand(op_b);
					run_job(OP_SIGNED, op_a, op_b);
				end
				stalled_done = 1'b1;
			end
			begin
				// Longer than a whole lane job, so a launch that was not held is seen
				repeat (3 * (DW + 2)) @(posedge clk);
				if (stalled_done)
				begin
					fail_count++;
					$display("Launch was accepted while every lane and the FIFO were full");
				end
				else
				begin
					pass_count++;
					$display("Pass launch held under back-pressure");
				end
				drain_and_compare(N_FULL + 2);
			end
		join

		if (exp_q.size() != 0)
		begin
			fail_count++;
			$display("%0d expected results were never read back", exp_q.size());
		end
		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Limit scales with the number of jobs in the run
	initial
	begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- seq_mult_array.f
logic/mult_pkg.sv
logic/job_dispatch.sv
logic/shift_add_lane.sv
logic/result_collect.sv
logic/seq_mult_array.sv
verif/seq_mult_array_checker.sv
verif/seq_mult_array_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the multiplier array testbench with Verilator and runs it
# The run counts as passed only if the pass message shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module seq_mult_array_tb \
	-Mdir obj_dir -f seq_mult_array.f \
	|| { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/Vseq_mult_array_tb)"
echo "$sim_output"
echo "$sim_output" | grep -q "TEST PASSED" && exit 0 || exit 1
